//--- verilog/rv32_pipe_pkg.sv
package rv32_pipe_pkg;

    // RV32I field widths
    localparam int unsigned word_width   = 32;
    localparam int unsigned reg_width    = 5;
    localparam int unsigned opcode_width = 7;
    localparam int unsigned pcsel_width  = 2;

    // Instruction, PC and address word
    typedef logic [word_width-1:0] rv32i_word;

    // Architectural register index
    typedef logic [reg_width-1:0] rv32i_reg;

    // Major opcodes, bits [6:0] of the instruction
    typedef enum logic [opcode_width-1:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_csr   = 7'b1110011
    } rv32i_opcode;

    // Next-PC source
    // alu_out sits at 1 so a branch can select it straight from br_en
    typedef enum logic [pcsel_width-1:0] {
        pc_plus4 = 2'd0,
        alu_out  = 2'd1,
        alu_mod2 = 2'd2
    } pcmux_sel_t;

    // addi x0, x0, 0 loaded into a flushed stage
    localparam rv32i_word nop_instr = 32'h0000_0013;

    // Fetch address after reset
    localparam rv32i_word pc_reset = 32'h0000_0000;

endpackage : rv32_pipe_pkg

//--- verilog/hazard_unit.sv
module hazard_unit (
    // Memory responses
    input  logic                      imem_resp,
    input  logic                      dmem_resp,

    // ID stage sources
    input  rv32_pipe_pkg::rv32i_reg   rs1_id,
    input  rv32_pipe_pkg::rv32i_reg   rs2_id,

    // EX stage contents with the opcode already masked by valid
    input  logic                      br_en,
    input  rv32_pipe_pkg::rv32i_opcode opcode,
    input  rv32_pipe_pkg::rv32i_reg   rd_ex,

    // MEM stage requests
    input  logic                      dmem_read_mem,
    input  logic                      dmem_write_mem,

    // PC control
    output logic                      pc_en,
    output rv32_pipe_pkg::pcmux_sel_t pcmux_sel,

    // Stage enables and flushes
    output logic                      ifid_en,
    output logic                      idex_en,
    output logic                      exmem_en,
    output logic                      memwb_en,
    output logic                      ifid_flush,
    output logic                      idex_flush
);
    import rv32_pipe_pkg::*;

    logic branch_taken;
    logic jump_instr;
    logic br_j_flush;
    logic dmem_request;
    logic load_use_hazard;

    // Static not-taken prediction makes a taken branch a mispredict
    assign branch_taken = br_en && (opcode == op_br);
    assign jump_instr   = (opcode == op_jal) || (opcode == op_jalr);
    assign br_j_flush   = branch_taken || jump_instr;

    assign dmem_request = dmem_read_mem || dmem_write_mem;

    // x0 as destination still matches here
    assign load_use_hazard = (opcode == op_load) && ((rd_ex == rs1_id) || (rd_ex == rs2_id));

    // Advance the PC with IF/ID or follow a redirect even while frozen
    assign pc_en = (ifid_en && !ifid_flush) || br_j_flush;

    always_comb begin
        case (opcode)
            op_br:   pcmux_sel = pcmux_sel_t'({1'b0, br_en});
            op_jal:  pcmux_sel = alu_out;
            op_jalr: pcmux_sel = alu_mod2;
            default: pcmux_sel = pc_plus4;
        endcase
    end

    always_comb begin
        ifid_en    = 1'b0;
        idex_en    = 1'b0;
        exmem_en   = 1'b0;
        memwb_en   = 1'b0;
        ifid_flush = 1'b0;
        idex_flush = 1'b0;

        // Memory-driven stall decisions
        if ((imem_resp && dmem_resp) || (imem_resp && !dmem_request)) begin
            ifid_en  = 1'b1;
            idex_en  = 1'b1;
            exmem_en = 1'b1;
            memwb_en = 1'b1;
        end else if (!imem_resp && !dmem_request) begin
            // Fetch miss turns into a bubble in IF/ID
            ifid_en    = 1'b1;
            idex_en    = 1'b1;
            exmem_en   = 1'b1;
            memwb_en   = 1'b1;
            ifid_flush = 1'b1;
        end

        if (br_j_flush) begin
            ifid_flush = 1'b1;
            idex_flush = 1'b1;
        end

        // Hold the consumer in ID and send a bubble to EX
        if (load_use_hazard) begin
            idex_flush = 1'b1;
            ifid_en    = 1'b0;
        end
    end

    a_load_use_hold: assert final (!(load_use_hazard && !br_j_flush) || !(ifid_en && pc_en))
        else $error("hazard_unit: PC and IF/ID advance during a load-use stall");

    // Without a redirect the next PC is always the sequential one
    a_seq_select: assert final (br_j_flush || pcmux_sel == pc_plus4)
        else $error("hazard_unit: redirect selected for opcode %h", opcode);

endmodule : hazard_unit

//--- verilog/pc_unit.sv
module pc_unit (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      pc_en,
    input  rv32_pipe_pkg::pcmux_sel_t pcmux_sel,
    input  rv32_pipe_pkg::rv32i_word  alu_out,
    output rv32_pipe_pkg::rv32i_word  pc
);
    import rv32_pipe_pkg::*;

    rv32i_word pc_next;

    // The port hides the enum label of the same name
    always_comb begin
        case (pcmux_sel)
            rv32_pipe_pkg::alu_out: pc_next = alu_out;
            alu_mod2:               pc_next = {alu_out[word_width-1:1], 1'b0};
            pc_plus4:               pc_next = pc + 32'd4;
            default:                pc_next = pc + 32'd4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= pc_reset;
        end else if (pc_en) begin
            pc <= pc_next;
        end
    end

    // Alignment carries over from the chosen target
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (reset)
        (pc_en && pc[1:0] == 2'b00 && alu_out[1] == 1'b0
            && (alu_out[0] == 1'b0 || pcmux_sel == alu_mod2))
        |=> (pc[1:0] == 2'b00)
    ) else $error("pc_unit: misaligned pc %h from aligned target", pc);

endmodule : pc_unit

//--- verilog/if_id_stage.sv
module if_id_stage (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     ifid_en,
    input  logic                     ifid_flush,
    input  rv32_pipe_pkg::rv32i_word pc,
    input  rv32_pipe_pkg::rv32i_word imem_rdata,
    output logic                     valid_id,
    output rv32_pipe_pkg::rv32i_word instr_id,
    output rv32_pipe_pkg::rv32i_reg  rs1_id,
    output rv32_pipe_pkg::rv32i_reg  rs2_id
);
    import rv32_pipe_pkg::*;

    rv32i_word pc_id;

    // Flush wins over hold and loads even with the enable low
    always_ff @(posedge clk) begin
        if (reset || ifid_flush) begin
            valid_id <= 1'b0;
            instr_id <= nop_instr;
        end else if (ifid_en) begin
            valid_id <= 1'b1;
            instr_id <= imem_rdata;
        end
    end

    // Fetch address of the held word
    always_ff @(posedge clk) begin
        if (ifid_en && !ifid_flush) begin
            pc_id <= pc;
        end
    end

    assign rs1_id = instr_id[19:15];
    assign rs2_id = instr_id[24:20];

    a_flush_bubble: assert property (
        @(posedge clk) disable iff (reset) ifid_flush |=> !valid_id
    ) else $error("if_id_stage: valid instruction after flush");

    // A valid word was fetched from a word-aligned address
    a_pc_capture: assert property (
        @(posedge clk) disable iff (reset) valid_id |-> (pc_id[1:0] == 2'b00)
    ) else $error("if_id_stage: held pc %h is not word aligned", pc_id);

endmodule : if_id_stage

//--- verilog/id_ex_stage.sv
module id_ex_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       idex_en,
    input  logic                       idex_flush,
    input  logic                       valid_id,
    input  rv32_pipe_pkg::rv32i_word   instr_id,
    output logic                       valid_ex,
    output rv32_pipe_pkg::rv32i_opcode opcode_ex,
    output rv32_pipe_pkg::rv32i_reg    rd_ex
);
    import rv32_pipe_pkg::*;

    rv32i_opcode opcode_id;
    rv32i_reg    rd_id;

    // Fields EX needs from the ID word
    assign opcode_id = rv32i_opcode'(instr_id[opcode_width-1:0]);
    assign rd_id     = instr_id[11:7];

    always_ff @(posedge clk) begin
        if (reset || idex_flush) begin
            // Bubble looks like addi x0
            valid_ex  <= 1'b0;
            opcode_ex <= op_imm;
            rd_ex     <= '0;
        end else if (idex_en) begin
            valid_ex  <= valid_id;
            opcode_ex <= opcode_id;
            rd_ex     <= rd_id;
        end
    end

endmodule : id_ex_stage

//--- verilog/mem_wb_track.sv
module mem_wb_track (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       exmem_en,
    input  logic                       memwb_en,
    input  logic                       valid_ex,
    input  rv32_pipe_pkg::rv32i_opcode opcode_ex,
    input  rv32_pipe_pkg::rv32i_reg    rd_ex,
    output logic                       dmem_read,
    output logic                       dmem_write,
    output logic                       wb_valid,
    output rv32_pipe_pkg::rv32i_opcode wb_opcode,
    output rv32_pipe_pkg::rv32i_reg    wb_rd
);
    import rv32_pipe_pkg::*;

    logic        valid_mem;
    rv32i_opcode opcode_mem;
    rv32i_reg    rd_mem;

    // EX/MEM
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_mem  <= 1'b0;
            opcode_mem <= op_imm;
            rd_mem     <= '0;
        end else if (exmem_en) begin
            valid_mem  <= valid_ex;
            opcode_mem <= opcode_ex;
            rd_mem     <= rd_ex;
        end
    end

    // Levels held for as long as the access sits in MEM
    assign dmem_read  = valid_mem && (opcode_mem == op_load);
    assign dmem_write = valid_mem && (opcode_mem == op_store);

    // MEM/WB, reports the retiring instruction
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid  <= 1'b0;
            wb_opcode <= op_imm;
            wb_rd     <= '0;
        end else if (memwb_en) begin
            wb_valid  <= valid_mem;
            wb_opcode <= opcode_mem;
            wb_rd     <= rd_mem;
        end
    end

    a_one_access: assert property (
        @(posedge clk) disable iff (reset) !(dmem_read && dmem_write)
    ) else $error("mem_wb_track: read and write requested together");

endmodule : mem_wb_track

//--- verilog/pipeline_control_top.sv
module pipeline_control_top (
    input  logic                       clk,
    input  logic                       reset,

    // Memory responses
    input  logic                       imem_resp,
    input  logic                       dmem_resp,
    input  rv32_pipe_pkg::rv32i_word   imem_rdata,

    // External EX datapath
    input  logic                       br_en,
    input  rv32_pipe_pkg::rv32i_word   alu_out,

    output rv32_pipe_pkg::rv32i_word   pc,
    output logic                       dmem_read,
    output logic                       dmem_write,
    output logic                       wb_valid,
    output rv32_pipe_pkg::rv32i_opcode wb_opcode,
    output rv32_pipe_pkg::rv32i_reg    wb_rd
);
    import rv32_pipe_pkg::*;

    logic        pc_en;
    pcmux_sel_t  pcmux_sel;
    logic        ifid_en;
    logic        idex_en;
    logic        exmem_en;
    logic        memwb_en;
    logic        ifid_flush;
    logic        idex_flush;
    logic        valid_id;
    rv32i_word   instr_id;
    rv32i_reg    rs1_id;
    rv32i_reg    rs2_id;
    logic        valid_ex;
    rv32i_opcode opcode_ex;
    rv32i_reg    rd_ex;
    rv32i_opcode opcode_hz;

    // Bubbles in EX decode as op_imm
    assign opcode_hz = valid_ex ? opcode_ex : op_imm;

    hazard_unit i_hazard_unit (
        .imem_resp     (imem_resp),
        .dmem_resp     (dmem_resp),
        .rs1_id        (rs1_id),
        .rs2_id        (rs2_id),
        .br_en         (br_en),
        .opcode        (opcode_hz),
        .rd_ex         (rd_ex),
        .dmem_read_mem (dmem_read),
        .dmem_write_mem(dmem_write),
        .pc_en         (pc_en),
        .pcmux_sel     (pcmux_sel),
        .ifid_en       (ifid_en),
        .idex_en       (idex_en),
        .exmem_en      (exmem_en),
        .memwb_en      (memwb_en),
        .ifid_flush    (ifid_flush),
        .idex_flush    (idex_flush)
    );

    pc_unit i_pc_unit (
        .clk      (clk),
        .reset    (reset),
        .pc_en    (pc_en),
        .pcmux_sel(pcmux_sel),
        .alu_out  (alu_out),
        .pc       (pc)
    );

    if_id_stage i_if_id_stage (
        .clk       (clk),
        .reset     (reset),
        .ifid_en   (ifid_en),
        .ifid_flush(ifid_flush),
        .pc        (pc),
        .imem_rdata(imem_rdata),
        .valid_id  (valid_id),
        .instr_id  (instr_id),
        .rs1_id    (rs1_id),
        .rs2_id    (rs2_id)
    );

    id_ex_stage i_id_ex_stage (
        .clk       (clk),
        .reset     (reset),
        .idex_en   (idex_en),
        .idex_flush(idex_flush),
        .valid_id  (valid_id),
        .instr_id  (instr_id),
        .valid_ex  (valid_ex),
        .opcode_ex (opcode_ex),
        .rd_ex     (rd_ex)
    );

    mem_wb_track i_mem_wb_track (
        .clk       (clk),
        .reset     (reset),
        .exmem_en  (exmem_en),
        .memwb_en  (memwb_en),
        .valid_ex  (valid_ex),
        .opcode_ex (opcode_ex),
        .rd_ex     (rd_ex),
        .dmem_read (dmem_read),
        .dmem_write(dmem_write),
        .wb_valid  (wb_valid),
        .wb_opcode (wb_opcode),
        .wb_rd     (wb_rd)
    );

endmodule : pipeline_control_top

//--- sim/pipeline_checker.sv
module pipeline_checker (
    input  logic                       clk,
    input  logic                       reset,
    input  int                         test_id,
    input  logic                       imem_resp,
    input  logic                       dmem_resp,
    input  logic                       br_en,
    input  rv32_pipe_pkg::rv32i_word   imem_rdata,
    input  rv32_pipe_pkg::rv32i_word   alu_out,
    input  rv32_pipe_pkg::rv32i_word   pc,
    input  logic                       dmem_read,
    input  logic                       dmem_write,
    input  logic                       wb_valid,
    input  rv32_pipe_pkg::rv32i_opcode wb_opcode,
    input  rv32_pipe_pkg::rv32i_reg    wb_rd,
    output int                         error_count,
    output int                         check_count
);
    timeunit 1ns;
    timeprecision 1ps;

    import rv32_pipe_pkg::*;

    // Shadow pipeline state
    rv32i_word   m_pc;
    logic        m_valid_id;
    rv32i_word   m_instr_id;
    logic        m_valid_ex;
    rv32i_opcode m_op_ex;
    rv32i_reg    m_rd_ex;
    logic        m_valid_mem;
    rv32i_opcode m_op_mem;
    rv32i_reg    m_rd_mem;
    logic        m_valid_wb;
    rv32i_opcode m_op_wb;
    rv32i_reg    m_rd_wb;

    int cur_test = 0;
    int test_checks = 0;
    int test_errors = 0;

    initial begin
        error_count = 0;
        check_count = 0;
    end

    always @(posedge clk) begin : model_step
        rv32i_opcode ex_op;
        logic        data_req;
        logic        redirect;
        logic        load_use;
        logic        advance;
        logic        if_flush;
        logic        id_flush;

        ex_op    = m_valid_ex ? m_op_ex : op_imm;
        data_req = m_valid_mem && (m_op_mem == op_load || m_op_mem == op_store);
        redirect = (ex_op == op_br && br_en) || ex_op == op_jal || ex_op == op_jalr;
        // Destination x0 still counts as a match
        load_use = (ex_op == op_load)
                   && (m_rd_ex == m_instr_id[19:15] || m_rd_ex == m_instr_id[24:20]);
        // A fetch miss also stalls while data is pending
        advance  = !data_req || (imem_resp && dmem_resp);
        if_flush = redirect || (!imem_resp && !data_req);
        id_flush = redirect || load_use;

        if (reset) begin
            m_pc        <= pc_reset;
            m_valid_id  <= 1'b0;
            m_instr_id  <= nop_instr;
            m_valid_ex  <= 1'b0;
            m_op_ex     <= op_imm;
            m_rd_ex     <= '0;
            m_valid_mem <= 1'b0;
            m_op_mem    <= op_imm;
            m_rd_mem    <= '0;
            m_valid_wb  <= 1'b0;
            m_op_wb     <= op_imm;
            m_rd_wb     <= '0;
        end else begin
            if (redirect) begin
                m_pc <= (ex_op == op_jalr) ? {alu_out[31:1], 1'b0} : alu_out;
            end else if (advance && !load_use && !if_flush) begin
                m_pc <= m_pc + 32'd4;
            end

            if (if_flush) begin
                m_valid_id <= 1'b0;
                m_instr_id <= nop_instr;
            end else if (advance && !load_use) begin
                m_valid_id <= 1'b1;
                m_instr_id <= imem_rdata;
            end

            if (id_flush) begin
                m_valid_ex <= 1'b0;
                m_op_ex    <= op_imm;
                m_rd_ex    <= '0;
            end else if (advance) begin
                m_valid_ex <= m_valid_id;
                m_op_ex    <= rv32i_opcode'(m_instr_id[6:0]);
                m_rd_ex    <= m_instr_id[11:7];
            end

            if (advance) begin
                m_valid_mem <= m_valid_ex;
                m_op_mem    <= m_op_ex;
                m_rd_mem    <= m_rd_ex;
                m_valid_wb  <= m_valid_mem;
                m_op_wb     <= m_op_mem;
                m_rd_wb     <= m_rd_mem;
            end
        end
    end

    task automatic compare_value(string name, logic [31:0] got, logic [31:0] exp);
        check_count++;
        test_checks++;
        if (got !== exp) begin
            error_count++;
            test_errors++;
            $display("FAILED %s: got %h, expected %h at %0t ns", name, got, exp, $time);
        end
    endtask

    task automatic report_test();
        if (test_errors == 0) begin
            $display("test %0d ok: %0d checks", cur_test, test_checks);
        end else begin
            $display("test %0d has %0d mismatches in %0d checks",
                     cur_test, test_errors, test_checks);
        end
    endtask

    // Outputs are settled halfway through the cycle
    always @(negedge clk) begin
        if (test_id != cur_test) begin
            if (cur_test != 0) begin
                report_test();
            end
            cur_test    = test_id;
            test_checks = 0;
            test_errors = 0;
        end
        if (!reset && test_id != 0) begin
            compare_value("pc", pc, m_pc);
            compare_value("dmem_read", 32'(dmem_read), 32'(m_valid_mem && m_op_mem == op_load));
            compare_value("dmem_write", 32'(dmem_write),
                          32'(m_valid_mem && m_op_mem == op_store));
            compare_value("wb_valid", 32'(wb_valid), 32'(m_valid_wb));
            compare_value("wb_opcode", 32'(wb_opcode), 32'(m_op_wb));
            compare_value("wb_rd", 32'(wb_rd), 32'(m_rd_wb));
        end
    end

endmodule : pipeline_checker

//--- sim/tb_pipeline_control.sv
module tb_pipeline_control;
    timeunit 1ns;
    timeprecision 1ps;

    import rv32_pipe_pkg::*;

    typedef struct {
        int        test_id;
        rv32i_word word;
        rv32i_word rand_mask;
        logic      imem_resp;
        logic      dmem_resp;
        logic      br_en;
        rv32i_word alu_out;
    } stim_row_t;

    // Random bits above the opcode field
    localparam rv32i_word filler_mask = 32'hffff_ff80;
    localparam rv32i_word base_target = 32'h0000_0200;

    logic        clk = 1'b0;
    logic        reset;
    logic        imem_resp;
    logic        dmem_resp;
    logic        br_en;
    rv32i_word   imem_rdata;
    rv32i_word   alu_out;
    rv32i_word   pc;
    logic        dmem_read;
    logic        dmem_write;
    logic        wb_valid;
    rv32i_opcode wb_opcode;
    rv32i_reg    wb_rd;
    int          test_id;
    int          error_count;
    int          check_count;
    integer      seed;
    stim_row_t   rows[$];

    always #4 clk = ~clk;

    pipeline_control_top i_dut (
        .clk       (clk),
        .reset     (reset),
        .imem_resp (imem_resp),
        .dmem_resp (dmem_resp),
        .imem_rdata(imem_rdata),
        .br_en     (br_en),
        .alu_out   (alu_out),
        .pc        (pc),
        .dmem_read (dmem_read),
        .dmem_write(dmem_write),
        .wb_valid  (wb_valid),
        .wb_opcode (wb_opcode),
        .wb_rd     (wb_rd)
    );

    pipeline_checker i_checker (
        .clk        (clk),
        .reset      (reset),
        .test_id    (test_id),
        .imem_resp  (imem_resp),
        .dmem_resp  (dmem_resp),
        .br_en      (br_en),
        .imem_rdata (imem_rdata),
        .alu_out    (alu_out),
        .pc         (pc),
        .dmem_read  (dmem_read),
        .dmem_write (dmem_write),
        .wb_valid   (wb_valid),
        .wb_opcode  (wb_opcode),
        .wb_rd      (wb_rd),
        .error_count(error_count),
        .check_count(check_count)
    );

    function automatic rv32i_word encode(rv32i_opcode op, rv32i_reg rd, rv32i_reg rs1,
                                         rv32i_reg rs2);
        return {7'b0, rs2, rs1, 3'b0, rd, op};
    endfunction

    task automatic add_row(int id, rv32i_word word, rv32i_word mask, logic ir, logic dr,
                           logic br, rv32i_word target);
        stim_row_t row;
        row.test_id   = id;
        row.word      = word;
        row.rand_mask = mask;
        row.imem_resp = ir;
        row.dmem_resp = dr;
        row.br_en     = br;
        row.alu_out   = target;
        rows.push_back(row);
    endtask

    task automatic add_fixed(int id, rv32i_word word);
        add_row(id, word, '0, 1'b1, 1'b1, 1'b0, base_target);
    endtask

    task automatic add_filler(int id, rv32i_opcode op, int count);
        repeat (count) add_row(id, encode(op, 0, 0, 0), filler_mask, 1'b1, 1'b1, 1'b0,
                               base_target);
    endtask

    task automatic add_miss(int id, int count);
        repeat (count) add_row(id, nop_instr, filler_mask, 1'b0, 1'b1, 1'b0, base_target);
    endtask

    // Data memory holds off its response
    task automatic add_wait(int id, int count);
        repeat (count) add_row(id, encode(op_imm, 0, 0, 0), filler_mask, 1'b1, 1'b0, 1'b0,
                               base_target);
    endtask

    // NOPs so the test's own words retire before the next test starts
    task automatic add_pad(int id);
        repeat (4) add_fixed(id, nop_instr);
    endtask

    task automatic build_table();
        // 1: straight-line fetch
        add_filler(1, op_imm, 4);
        add_filler(1, op_reg, 2);
        add_pad(1);
        // 2: fetch miss
        add_filler(2, op_imm, 2);
        add_miss(2, 2);
        add_filler(2, op_lui, 2);
        add_pad(2);
        // 3: taken branch, not-taken branch, jal
        add_fixed(3, encode(op_br, 0, 3, 4));
        add_filler(3, op_imm, 1);
        add_row(3, encode(op_imm, 0, 0, 0), filler_mask, 1'b1, 1'b1, 1'b1, 32'h0000_0300);
        add_filler(3, op_imm, 2);
        add_fixed(3, encode(op_br, 0, 5, 6));
        add_filler(3, op_reg, 3);
        add_fixed(3, encode(op_jal, 1, 0, 0));
        add_filler(3, op_imm, 2);
        add_pad(3);
        // 4: jalr with an odd target
        add_fixed(4, encode(op_jalr, 1, 2, 0));
        add_filler(4, op_imm, 1);
        add_row(4, encode(op_imm, 0, 0, 0), filler_mask, 1'b1, 1'b1, 1'b0, 32'h0000_0405);
        add_filler(4, op_imm, 2);
        add_pad(4);
        // 5: load-use on rs1, then a load without a consumer
        add_fixed(5, encode(op_load, 5, 0, 0));
        add_fixed(5, encode(op_reg, 6, 5, 7));
        add_filler(5, op_imm, 3);
        add_fixed(5, encode(op_load, 8, 0, 0));
        add_fixed(5, encode(op_reg, 9, 10, 11));
        add_filler(5, op_imm, 2);
        add_pad(5);
        // 6: load and store waiting on the data memory
        add_fixed(6, encode(op_load, 12, 0, 0));
        add_fixed(6, encode(op_imm, 1, 2, 3));
        add_filler(6, op_imm, 1);
        add_wait(6, 3);
        add_filler(6, op_imm, 2);
        add_fixed(6, encode(op_store, 0, 1, 2));
        add_fixed(6, encode(op_imm, 1, 2, 3));
        add_filler(6, op_imm, 1);
        add_wait(6, 3);
        add_filler(6, op_imm, 2);
        add_pad(6);
    endtask

    initial begin : stimulus
        stim_row_t row;
        rv32i_word word;
        seed       = 32'h76ef72af;
        reset      = 1'b1;
        imem_resp  = 1'b0;
        dmem_resp  = 1'b1;
        br_en      = 1'b0;
        imem_rdata = nop_instr;
        alu_out    = base_target;
        test_id    = 0;
        build_table();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        foreach (rows[i]) begin
            row  = rows[i];
            word = (row.word & ~row.rand_mask) | ($random(seed) & row.rand_mask);
            imem_rdata <= word;
            imem_resp  <= row.imem_resp;
            dmem_resp  <= row.dmem_resp;
            br_en      <= row.br_en;
            alu_out    <= row.alu_out;
            test_id    <= row.test_id;
            @(posedge clk);
        end
        // Id 0 closes the last test in the checker
        test_id <= 0;
        repeat (2) @(posedge clk);
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        int timeout_ns;
        wait (rows.size() != 0);
        timeout_ns = (rows.size() + 20) * 8;
        #(timeout_ns);
        $display("Timeout: the stimulus table did not finish within %0d ns", timeout_ns);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule : tb_pipeline_control

//--- sim.f
verilog/rv32_pipe_pkg.sv
verilog/hazard_unit.sv
verilog/pc_unit.sv
verilog/if_id_stage.sv
verilog/id_ex_stage.sv
verilog/mem_wb_track.sv
verilog/pipeline_control_top.sv
sim/pipeline_checker.sv
sim/tb_pipeline_control.sv

//--- Bender.yml
package:
  name: pipeline_control

sources:
  - verilog/rv32_pipe_pkg.sv
  - verilog/hazard_unit.sv
  - verilog/pc_unit.sv
  - verilog/if_id_stage.sv
  - verilog/id_ex_stage.sv
  - verilog/mem_wb_track.sv
  - verilog/pipeline_control_top.sv
  - target: simulation
    files:
      - sim/pipeline_checker.sv
      - sim/tb_pipeline_control.sv
